/* project.f */
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
bench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f project.f --top-module tb_core \
	--Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/tb_core_sim)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// galois lfsr stepped once per bit taken
function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		bits  = {bits[30:0], state[0]};
		state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	end
	return bits;
endfunction

// left counts the words still before the closing self-loop
function automatic rv_pkg::word_t gen_inst(inout logic [31:0] state,
	input rv_pkg::word_t pc, input int left);
	logic [31:0]   r;
	logic [2:0]    f3;
	logic [6:0]    f7;
	logic [4:0]    rd;
	rv_pkg::word_t off;
	rv_pkg::word_t tgt;
	r   = lfsr_take(state, 32);
	f3  = r[5:3];
	rd  = {2'b0, r[8:6]};
	off = r[28] ? 32'd12 : 32'd8;
	tgt = pc + off;
	f7  = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[27], 5'b0} : 7'b0;
	if (r[2:0] == 3'd6 && left >= 3) begin
		if (f3[2:1] == 2'b01)
			f3[1] = 1'b0;
		return {7'b0, 2'b0, r[14:12], 2'b0, r[11:9], f3, off[4:1], 1'b0, 7'b1100011};
	end
	if (r[2:0] == 3'd7 && left >= 3) begin
		if (r[29] && tgt < 32'd2048)
			return {tgt[11:0], 5'd0, 3'b000, rd, 7'b1100111};
		return {1'b0, off[10:1], 1'b0, 8'b0, rd, 7'b1101111};
	end
	case (r[2:0])
		3'd4, 3'd6: return {r[31:12], rd, 7'b0110111};
		3'd5, 3'd7: return {r[31:12], rd, 7'b0010111};
		3'd0, 3'd1: return {f7, 2'b0, r[14:12], 2'b0, r[11:9], f3, rd, 7'b0110011};
		default: begin
			if (f3 == 3'b001 || f3 == 3'b101)
				return {f7, r[19:15], 2'b0, r[11:9], f3, rd, 7'b0010011};
			return {r[26:15], 2'b0, r[11:9], f3, rd, 7'b0010011};
		end
	endcase
endfunction

function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
	input rv_pkg::word_t a, input rv_pkg::word_t b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return {31'b0, $signed(a) < $signed(b)};
		3'b011:  return {31'b0, a < b};
		3'b100:  return a ^ b;
		3'b101:  return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

// runs one instruction and updates the register copy and the pc
function automatic rv_pkg::commit_t ref_step(inout rv_pkg::word_t rf [32],
	inout rv_pkg::word_t pc, input rv_pkg::word_t inst);
	rv_pkg::commit_t c;
	rv_pkg::word_t   a;
	rv_pkg::word_t   b;
	rv_pkg::word_t   imm;
	rv_pkg::word_t   next_pc;
	logic            taken;
	a       = rf[inst[19:15]];
	b       = rf[inst[24:20]];
	imm     = {{20{inst[31]}}, inst[31:20]};
	next_pc = pc + 32'd4;
	c       = '{pc: pc, rd: inst[11:7], rd_wen: 1'b1, data: '0};
	case (rv_pkg::opcode_e'(inst[6:0]))
		rv_pkg::OPC_OP:     c.data = ref_alu(inst[14:12], inst[30], a, b);
		rv_pkg::OPC_OP_IMM: c.data = ref_alu(inst[14:12],
			inst[30] && inst[14:12] == 3'b101, a, imm);
		rv_pkg::OPC_LUI:    c.data = {inst[31:12], 12'b0};
		rv_pkg::OPC_AUIPC:  c.data = pc + {inst[31:12], 12'b0};
		rv_pkg::OPC_JAL: begin
			c.data  = pc + 32'd4;
			next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
				inst[30:21], 1'b0};
		end
		rv_pkg::OPC_JALR: begin
			c.data  = pc + 32'd4;
			next_pc = (a + imm) & ~32'd1;
		end
		rv_pkg::OPC_BRANCH: begin
			c.rd_wen = 1'b0;
			taken = inst[14] ? (inst[13] ? a < b : $signed(a) < $signed(b)) : (a == b);
			if (taken ^ inst[12])
				next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
					inst[11:8], 1'b0};
		end
		default: c.rd_wen = 1'b0;
	endcase
	if (c.rd_wen && c.rd != '0)
		rf[c.rd] = c.data;
	pc = next_pc;
	return c;
endfunction

`endif

/* bench/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

	localparam rv_pkg::word_t RESET_PC = 32'h0000_0000;
	localparam int PROG_WORDS     = 200;
	localparam int NUM_COMMITS    = 250;
	localparam int TIMEOUT_CYCLES = NUM_COMMITS * 12;

	logic            clock;
	logic            reset;
	logic            imem_req;
	rv_pkg::word_t   imem_addr;
	logic            imem_rvalid;
	rv_pkg::word_t   imem_rdata;
	logic            commit_valid;
	rv_pkg::commit_t commit;

	rv_pkg::word_t   prog [PROG_WORDS];
	logic [31:0]     lfsr_state;

	// memory responder state
	logic            rsp_busy;
	int              rsp_wait;
	rv_pkg::word_t   rsp_addr;

	// instruction-set model state
	rv_pkg::word_t   model_rf [32];
	rv_pkg::word_t   model_pc;
	rv_pkg::word_t   model_inst;
	rv_pkg::commit_t expected;
	int              commit_count;
	int              cycle_count;

	`include "tb_ref_model.svh"

	rv_core #(
		.RESET_PC (RESET_PC)
	) i_dut (
		.clock          (clock),
		.reset          (reset),
		.imem_req_o     (imem_req),
		.imem_addr_o    (imem_addr),
		.imem_rvalid_i  (imem_rvalid),
		.imem_rdata_i   (imem_rdata),
		.commit_valid_o (commit_valid),
		.commit_o       (commit)
	);

	always #50 clock = ~clock;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	function automatic string commit_text(input rv_pkg::commit_t c);
		return $sformatf("pc=%h rd=%0d rd_wen=%b data=%h", c.pc, c.rd, c.rd_wen, c.data);
	endfunction

	task automatic compare_commit(input string name, input rv_pkg::commit_t exp,
		input rv_pkg::commit_t act);
		if (act !== exp)
			stop_with_failure($sformatf("error %s expected %s actual %s", name,
				commit_text(exp), commit_text(act)));
	endtask

	function automatic logic in_program(input rv_pkg::word_t addr);
		return (addr[1:0] == 2'b00) && ((addr - RESET_PC) < PROG_WORDS * 4);
	endfunction

	function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
		return prog[(addr - RESET_PC) >> 2];
	endfunction

	function automatic string inst_kind(input rv_pkg::word_t inst);
		case (rv_pkg::opcode_e'(inst[6:0]))
			rv_pkg::OPC_OP:     return "alu_reg";
			rv_pkg::OPC_OP_IMM: return "alu_imm";
			rv_pkg::OPC_LUI:    return "lui";
			rv_pkg::OPC_AUIPC:  return "auipc";
			rv_pkg::OPC_JAL:    return "jal";
			rv_pkg::OPC_JALR:   return "jalr";
			rv_pkg::OPC_BRANCH: return "branch";
			default:            return "unknown";
		endcase
	endfunction

	// answers one request after 0 to 3 idle cycles
	always begin
		@(posedge clock);
		#1;
		imem_rvalid = 1'b0;
		if (reset) begin
			rsp_busy = 1'b0;
		end else if (rsp_busy) begin
			if (imem_req)
				stop_with_failure("second fetch request while one is outstanding");
			if (rsp_wait == 0) begin
				imem_rvalid = 1'b1;
				imem_rdata  = fetch_word(rsp_addr);
				rsp_busy    = 1'b0;
			end else begin
				rsp_wait = rsp_wait - 1;
			end
		end else if (imem_req) begin
			if (!in_program(imem_addr))
				stop_with_failure($sformatf("fetch address %h outside the program", imem_addr));
			rsp_addr = imem_addr;
			rsp_wait = int'(lfsr_take(lfsr_state, 2));
			rsp_busy = 1'b1;
		end
	end

	// one model step per commit
	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			model_inst = fetch_word(model_pc);
			expected   = ref_step(model_rf, model_pc, model_inst);
			compare_commit($sformatf("%s_%0d", inst_kind(model_inst), commit_count),
				expected, commit);
			commit_count = commit_count + 1;
		end
	end

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		imem_rvalid  = 1'b0;
		imem_rdata   = '0;
		rsp_busy     = 1'b0;
		rsp_wait     = 0;
		rsp_addr     = '0;
		commit_count = 0;
		cycle_count  = 0;
		lfsr_state   = 32'h948d7309;

		// last word is jal x0,0
		for (int i = 0; i < PROG_WORDS - 1; i++)
			prog[i] = gen_inst(lfsr_state, RESET_PC + 32'(4 * i), PROG_WORDS - 1 - i);
		prog[PROG_WORDS - 1] = 32'h0000006f;

		for (int i = 0; i < 32; i++)
			model_rf[i] = '0;
		model_pc = RESET_PC;

		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		while (commit_count < NUM_COMMITS && cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end

		if (commit_count >= NUM_COMMITS) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_with_failure($sformatf("commits stopped at %0d of %0d after %0d cycles",
				commit_count, NUM_COMMITS, cycle_count));
		end
	end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
	parameter rv_pkg::word_t RESET_PC = '0
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic                 imem_req_o,
	output rv_pkg::word_t        imem_addr_o,
	input  logic                 imem_rvalid_i,
	input  rv_pkg::word_t        imem_rdata_i,
	output logic                 commit_valid_o,
	output rv_pkg::commit_t      commit_o
);

	rv_pkg::fetch_t    if_data;
	rv_pkg::decoded_t  id_data;
	rv_pkg::exec_t     ex_fwd;
	rv_pkg::exec_t     ex_data;
	rv_pkg::exec_t     wb_fwd;
	rv_pkg::reg_addr_t rs1_addr;
	rv_pkg::reg_addr_t rs2_addr;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	rv_pkg::reg_addr_t rf_waddr;
	rv_pkg::word_t     rf_wdata;
	rv_pkg::word_t     redirect_pc;
	logic              rf_wen;
	logic              redirect_valid;
	logic              if_valid;
	logic              if_ready;
	logic              if_fire;
	logic              id_valid;
	logic              id_ready;
	logic              id_fire;
	logic              ex_valid;
	logic              ex_ready;
	logic              ex_fire;
	logic              wb_valid;

	assign if_fire  = if_valid & if_ready;
	assign id_fire  = id_valid & id_ready;
	assign ex_ready = ~wb_valid;
	assign ex_fire  = ex_valid & ex_ready;

	// a ready drops after an item enters and rises once it moves on
	always_ff @(posedge clock) begin
		if (reset) begin
			if_ready <= 1'b1;
			id_valid <= 1'b0;
			id_ready <= 1'b1;
			ex_valid <= 1'b0;
		end else begin
			if (id_fire)
				if_ready <= 1'b1;
			else if (if_fire)
				if_ready <= 1'b0;

			if (if_fire)
				id_valid <= 1'b1;
			else if (id_fire)
				id_valid <= 1'b0;

			if (ex_fire)
				id_ready <= 1'b1;
			else if (id_fire)
				id_ready <= 1'b0;

			if (id_fire)
				ex_valid <= 1'b1;
			else if (ex_fire)
				ex_valid <= 1'b0;
		end
	end

	rv_fetch #(
		.RESET_PC (RESET_PC)
	) i_fetch (
		.clock            (clock),
		.reset            (reset),
		.imem_req_o       (imem_req_o),
		.imem_addr_o      (imem_addr_o),
		.imem_rvalid_i    (imem_rvalid_i),
		.imem_rdata_i     (imem_rdata_i),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.if_ready_i       (if_ready),
		.if_valid_o       (if_valid),
		.if_data_o        (if_data)
	);

	rv_decode i_decode (
		.clock      (clock),
		.reset      (reset),
		.if_data_i  (if_data),
		.if_fire_i  (if_fire),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_fwd_i   (ex_fwd),
		.ex_valid_i (ex_valid),
		.wb_fwd_i   (wb_fwd),
		.wb_valid_i (wb_valid),
		.id_fire_i  (id_fire),
		.id_data_o  (id_data)
	);

	rv_regfile i_regfile (
		.clock      (clock),
		.reset      (reset),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wen_i      (rf_wen),
		.waddr_i    (rf_waddr),
		.wdata_i    (rf_wdata)
	);

	rv_execute i_execute (
		.clock     (clock),
		.reset     (reset),
		.id_data_i (id_data),
		.ex_fwd_o  (ex_fwd),
		.ex_fire_i (ex_fire),
		.ex_data_o (ex_data)
	);

	rv_writeback i_writeback (
		.clock            (clock),
		.reset            (reset),
		.ex_fire_i        (ex_fire),
		.ex_data_i        (ex_data),
		.wb_valid_o       (wb_valid),
		.wb_fwd_o         (wb_fwd),
		.rf_wen_o         (rf_wen),
		.rf_waddr_o       (rf_waddr),
		.rf_wdata_o       (rf_wdata),
		.redirect_valid_o (redirect_valid),
		.redirect_pc_o    (redirect_pc),
		.commit_valid_o   (commit_valid_o),
		.commit_o         (commit_o)
	);

endmodule

/* verilog/rv_writeback.sv */
`timescale 1ns/1ps

module rv_writeback (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 ex_fire_i,
	input  rv_pkg::exec_t        ex_data_i,
	output logic                 wb_valid_o,
	output rv_pkg::exec_t        wb_fwd_o,
	output logic                 rf_wen_o,
	output rv_pkg::reg_addr_t    rf_waddr_o,
	output rv_pkg::word_t        rf_wdata_o,
	output logic                 redirect_valid_o,
	output rv_pkg::word_t        redirect_pc_o,
	output logic                 commit_valid_o,
	output rv_pkg::commit_t      commit_o
);

	logic busy_q;

	// busy for one cycle per item and blocks the next execute transfer
	always_ff @(posedge clock) begin
		if (reset)
			busy_q <= 1'b0;
		else
			busy_q <= ex_fire_i;
	end

	assign wb_valid_o = busy_q;
	assign wb_fwd_o   = ex_data_i;

	assign rf_wen_o   = busy_q & ex_data_i.rd_wen;
	assign rf_waddr_o = ex_data_i.rd;
	assign rf_wdata_o = ex_data_i.result;

	assign redirect_valid_o = busy_q & ex_data_i.redirect;
	assign redirect_pc_o    = ex_data_i.target;

	assign commit_valid_o = busy_q;
	assign commit_o = '{
		pc:     ex_data_i.pc,
		rd:     ex_data_i.rd,
		rd_wen: ex_data_i.rd_wen,
		data:   ex_data_i.result
	};

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
	input  logic                 clock,
	input  logic                 reset,
	input  rv_pkg::decoded_t     id_data_i,
	output rv_pkg::exec_t        ex_fwd_o,
	input  logic                 ex_fire_i,
	output rv_pkg::exec_t        ex_data_o
);

	rv_pkg::word_t src1;
	rv_pkg::word_t src2;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_res;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t pc_imm;
	rv_pkg::word_t target;
	rv_pkg::word_t result;
	rv_pkg::exec_t ex_q;
	logic          taken;
	logic          jump;

	assign src1     = id_data_i.src1;
	assign src2     = id_data_i.src2;
	assign op_b     = id_data_i.use_imm ? id_data_i.imm : src2;
	assign pc_plus4 = id_data_i.pc + 32'd4;
	assign pc_imm   = id_data_i.pc + id_data_i.imm;
	assign jump     = id_data_i.jal | id_data_i.jalr;

	always_comb begin
		case (id_data_i.alu_op)
			rv_pkg::ALU_SUB:    alu_res = src1 - op_b;
			rv_pkg::ALU_SLL:    alu_res = src1 << op_b[4:0];
			rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(src1) < $signed(op_b)};
			rv_pkg::ALU_SLTU:   alu_res = {31'b0, src1 < op_b};
			rv_pkg::ALU_XOR:    alu_res = src1 ^ op_b;
			rv_pkg::ALU_SRL:    alu_res = src1 >> op_b[4:0];
			rv_pkg::ALU_SRA:    alu_res = rv_pkg::word_t'($signed(src1) >>> op_b[4:0]);
			rv_pkg::ALU_OR:     alu_res = src1 | op_b;
			rv_pkg::ALU_AND:    alu_res = src1 & op_b;
			rv_pkg::ALU_PASS_B: alu_res = op_b;
			default:            alu_res = src1 + op_b;
		endcase
	end

	// branch compare on the two register sources
	always_comb begin
		case (id_data_i.funct3)
			3'b000:  taken = (src1 == src2);
			3'b001:  taken = (src1 != src2);
			3'b100:  taken = ($signed(src1) < $signed(src2));
			3'b101:  taken = ($signed(src1) >= $signed(src2));
			3'b110:  taken = (src1 < src2);
			3'b111:  taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (id_data_i.jalr)
			target = (src1 + id_data_i.imm) & ~32'd1;
		else if (id_data_i.branch && !taken)
			target = pc_plus4;
		else
			target = pc_imm;
	end

	// branches commit zero data
	assign result = jump ? pc_plus4 : (id_data_i.branch ? '0 : alu_res);

	assign ex_fwd_o = '{
		pc:       id_data_i.pc,
		result:   result,
		rd:       id_data_i.rd,
		rd_wen:   id_data_i.rd_wen,
		redirect: jump | id_data_i.branch,
		target:   target
	};

	always_ff @(posedge clock) begin
		if (reset)
			ex_q <= '0;
		else if (ex_fire_i)
			ex_q <= ex_fwd_o;
	end

	assign ex_data_o = ex_q;

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
	input  logic                 clock,
	input  logic                 reset,
	input  rv_pkg::reg_addr_t    rs1_addr_i,
	input  rv_pkg::reg_addr_t    rs2_addr_i,
	output rv_pkg::word_t        rs1_data_o,
	output rv_pkg::word_t        rs2_data_o,
	input  logic                 wen_i,
	input  rv_pkg::reg_addr_t    waddr_i,
	input  rv_pkg::word_t        wdata_i
);

	rv_pkg::word_t regs [32];

	// x0 is cleared here and never written
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rs1_data_o = regs[rs1_addr_i];
	assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
	input  logic                 clock,
	input  logic                 reset,
	input  rv_pkg::fetch_t       if_data_i,
	input  logic                 if_fire_i,
	output rv_pkg::reg_addr_t    rs1_addr_o,
	output rv_pkg::reg_addr_t    rs2_addr_o,
	input  rv_pkg::word_t        rs1_data_i,
	input  rv_pkg::word_t        rs2_data_i,
	input  rv_pkg::exec_t        ex_fwd_i,
	input  logic                 ex_valid_i,
	input  rv_pkg::exec_t        wb_fwd_i,
	input  logic                 wb_valid_i,
	input  logic                 id_fire_i,
	output rv_pkg::decoded_t     id_data_o
);

	rv_pkg::fetch_t   if_q;
	rv_pkg::decoded_t dec;
	rv_pkg::decoded_t id_q;
	rv_pkg::word_t    inst;
	rv_pkg::opcode_e  opcode;
	rv_pkg::alu_op_e  funct_op;
	rv_pkg::word_t    imm_i;
	rv_pkg::word_t    imm_u;
	rv_pkg::word_t    imm_b;
	rv_pkg::word_t    imm_j;
	rv_pkg::word_t    rs1_val;
	rv_pkg::word_t    rs2_val;

	// youngest producer wins and x0 is never forwarded
	function automatic rv_pkg::word_t forward(input rv_pkg::reg_addr_t rs,
		input rv_pkg::word_t rf_data, input rv_pkg::exec_t ex, input logic ex_v,
		input rv_pkg::exec_t wb, input logic wb_v);
		if (rs != '0 && ex_v && ex.rd_wen && ex.rd == rs)
			return ex.result;
		if (rs != '0 && wb_v && wb.rd_wen && wb.rd == rs)
			return wb.result;
		return rf_data;
	endfunction

	always_ff @(posedge clock) begin
		if (if_fire_i)
			if_q <= if_data_i;
	end

	assign inst   = if_q.inst;
	assign opcode = rv_pkg::opcode_e'(inst[6:0]);
	assign imm_i  = {{20{inst[31]}}, inst[31:20]};
	assign imm_u  = {inst[31:12], 12'b0};
	assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rs1_addr_o = inst[19:15];
	assign rs2_addr_o = inst[24:20];
	assign rs1_val = forward(rs1_addr_o, rs1_data_i, ex_fwd_i, ex_valid_i,
		wb_fwd_i, wb_valid_i);
	assign rs2_val = forward(rs2_addr_o, rs2_data_i, ex_fwd_i, ex_valid_i,
		wb_fwd_i, wb_valid_i);

	// bit 30 picks sub on register ops only and sra on both
	always_comb begin
		case (inst[14:12])
			3'b000: funct_op = (opcode == rv_pkg::OPC_OP && inst[30]) ? rv_pkg::ALU_SUB
				: rv_pkg::ALU_ADD;
			3'b001: funct_op = rv_pkg::ALU_SLL;
			3'b010: funct_op = rv_pkg::ALU_SLT;
			3'b011: funct_op = rv_pkg::ALU_SLTU;
			3'b100: funct_op = rv_pkg::ALU_XOR;
			3'b101: funct_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: funct_op = rv_pkg::ALU_OR;
			default: funct_op = rv_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		dec        = '0;
		dec.pc     = if_q.pc;
		dec.src1   = rs1_val;
		dec.src2   = rs2_val;
		dec.imm    = imm_i;
		dec.alu_op = rv_pkg::ALU_ADD;
		dec.rd     = inst[11:7];
		dec.funct3 = inst[14:12];
		case (opcode)
			rv_pkg::OPC_OP: begin
				dec.alu_op = funct_op;
				dec.rd_wen = 1'b1;
			end
			rv_pkg::OPC_OP_IMM: begin
				dec.alu_op  = funct_op;
				dec.use_imm = 1'b1;
				dec.rd_wen  = 1'b1;
			end
			rv_pkg::OPC_LUI: begin
				dec.alu_op  = rv_pkg::ALU_PASS_B;
				dec.use_imm = 1'b1;
				dec.imm     = imm_u;
				dec.rd_wen  = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				dec.src1    = if_q.pc;
				dec.use_imm = 1'b1;
				dec.imm     = imm_u;
				dec.rd_wen  = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				dec.src1   = if_q.pc;
				dec.imm    = imm_j;
				dec.jal    = 1'b1;
				dec.rd_wen = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				dec.jalr   = 1'b1;
				dec.rd_wen = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				dec.imm    = imm_b;
				dec.branch = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			id_q <= '0;
		else if (id_fire_i)
			id_q <= dec;
	end

	assign id_data_o = id_q;

endmodule

/* verilog/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch #(
	parameter rv_pkg::word_t RESET_PC = '0
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic                 imem_req_o,
	output rv_pkg::word_t        imem_addr_o,
	input  logic                 imem_rvalid_i,
	input  rv_pkg::word_t        imem_rdata_i,
	input  logic                 redirect_valid_i,
	input  rv_pkg::word_t        redirect_pc_i,
	input  logic                 if_ready_i,
	output logic                 if_valid_o,
	output rv_pkg::fetch_t       if_data_o
);

	rv_pkg::fetch_state_e state_q;
	rv_pkg::word_t        pc_q;
	rv_pkg::word_t        inst_q;
	rv_pkg::opcode_e      opcode;
	logic                 req_q;
	logic                 is_ctrl;

	// pre-decode stops fetch behind any control transfer
	assign opcode  = rv_pkg::opcode_e'(inst_q[6:0]);
	assign is_ctrl = (opcode == rv_pkg::OPC_JAL) || (opcode == rv_pkg::OPC_JALR) ||
		(opcode == rv_pkg::OPC_BRANCH);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= rv_pkg::FS_REQUEST;
			pc_q    <= RESET_PC;
			req_q   <= 1'b0;
		end else begin
			req_q <= 1'b0;
			case (state_q)
				rv_pkg::FS_REQUEST: begin
					req_q   <= 1'b1;
					state_q <= rv_pkg::FS_WAIT_RSP;
				end
				rv_pkg::FS_WAIT_RSP: begin
					if (imem_rvalid_i)
						state_q <= rv_pkg::FS_HOLD;
				end
				rv_pkg::FS_HOLD: begin
					if (if_ready_i && is_ctrl) begin
						state_q <= rv_pkg::FS_WAIT_REDIRECT;
					end else if (if_ready_i) begin
						pc_q    <= pc_q + 32'd4;
						req_q   <= 1'b1;
						state_q <= rv_pkg::FS_WAIT_RSP;
					end
				end
				rv_pkg::FS_WAIT_REDIRECT: begin
					if (redirect_valid_i) begin
						pc_q    <= redirect_pc_i;
						req_q   <= 1'b1;
						state_q <= rv_pkg::FS_WAIT_RSP;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == rv_pkg::FS_WAIT_RSP && imem_rvalid_i)
			inst_q <= imem_rdata_i;
	end

	assign imem_req_o  = req_q;
	assign imem_addr_o = pc_q;
	assign if_valid_o  = (state_q == rv_pkg::FS_HOLD);
	assign if_data_o   = '{pc: pc_q, inst: inst_q, is_ctrl: is_ctrl};

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		FS_REQUEST,
		FS_WAIT_RSP,
		FS_HOLD,
		FS_WAIT_REDIRECT
	} fetch_state_e;

	typedef struct packed {
		word_t pc;
		word_t inst;
		logic  is_ctrl;
	} fetch_t;

	typedef struct packed {
		word_t     pc;
		word_t     src1;
		word_t     src2;
		word_t     imm;
		alu_op_e   alu_op;
		logic      use_imm;
		reg_addr_t rd;
		logic      rd_wen;
		logic      branch;
		logic      jal;
		logic      jalr;
		logic [2:0] funct3;
	} decoded_t;

	// redirect is set for every control transfer, taken or not
	typedef struct packed {
		word_t     pc;
		word_t     result;
		reg_addr_t rd;
		logic      rd_wen;
		logic      redirect;
		word_t     target;
	} exec_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		logic      rd_wen;
		word_t     data;
	} commit_t;

endpackage
